// ==== sources.f ====
+incdir+source
source/samplerz_pkg.sv
source/center_prep.sv
source/base_candidate.sv
source/exponent_calc.sv
source/bernoulli_accept.sv
source/sample_select.sv
source/samplerz_top.sv
tb/samplerz_asserts.sv
tb/samplerz_tb.sv

// ==== tb/samplerz_tb.sv ====
// testbench for the gaussian integer sampler
// vector table, reference model, result collector, compare tasks, watchdog
`timescale 1ns/100ps
`default_nettype none

`include "samplerz_defines.svh"

module samplerz_tb;

  localparam int CLK_PERIOD = 8;
  localparam int N_HAND     = 7;
  localparam int N_RAND     = 24;
  localparam int N_VECS     = N_HAND + N_RAND;

  localparam samplerz_pkg::fx_t   ISP_ONE  = 32'sd51287;   // ccs = 1.0 for the 512 set
  localparam samplerz_pkg::fx_t   ISP_LOW  = 32'sd45875;   // ccs ~ 0.89
  localparam samplerz_pkg::fx_t   ISP_EDGE = 32'sd50867;   // 512 rejects, 1024 accepts at 255
  localparam samplerz_pkg::fx_t   ISQ      = 32'sd20068;   // ~ isp^2 / 2
  localparam samplerz_pkg::rand_t R72_TOP  = 72'hFF_FFFF_FFFF_FFFF_FFFF;  // z0 = 0
  localparam samplerz_pkg::rand_t R72_Z0_1 = 72'h80_0000_0000_0000_0000;  // z0 = 1

  typedef struct packed {
    samplerz_pkg::fx_t   mu;
    samplerz_pkg::fx_t   isp;
    samplerz_pkg::fx_t   isq;
    bit                  ftype;
    samplerz_pkg::rand_t r72;
    logic [7:0]          r8;
    bit                  r1;
    bit                  acc;      // expected accept
    samplerz_pkg::zint_t w;        // expected sample
  } vec_t;

  typedef struct packed {
    int                  due;      // cycle of the result strobe
    bit                  acc;
    samplerz_pkg::zint_t w;
  } pending_t;

  logic                clk;
  logic                rst_i;
  logic                din_val_i;
  samplerz_pkg::fx_t   mu_i;
  samplerz_pkg::fx_t   inv_sigma_prime_i;
  samplerz_pkg::fx_t   isp_sqr_div_2_i;
  logic                falcon_type_i;
  logic                rand_val_i;
  samplerz_pkg::rand_t rand_72_i;
  logic [7:0]          rand_8_i;
  logic                rand_1_i;
  logic                dout_val_o;
  samplerz_pkg::zint_t w_o;
  logic                request_rand_o;

  vec_t     vecs [N_VECS];
  pending_t expect_q [$];          // attempts in flight, issue order
  int       cyc          = 0;
  int       checks       = 0;
  int       value_errors = 0;
  int       other_errors = 0;

  samplerz_top dut_i (
    .clk               (clk),
    .rst_i             (rst_i),
    .din_val_i         (din_val_i),
    .mu_i              (mu_i),
    .inv_sigma_prime_i (inv_sigma_prime_i),
    .isp_sqr_div_2_i   (isp_sqr_div_2_i),
    .falcon_type_i     (falcon_type_i),
    .rand_val_i        (rand_val_i),
    .rand_72_i         (rand_72_i),
    .rand_8_i          (rand_8_i),
    .rand_1_i          (rand_1_i),
    .dout_val_o        (dout_val_o),
    .w_o               (w_o),
    .request_rand_o    (request_rand_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;   // edge count, read between edges

  // ======================================================================
  // reference model, rules 1 to 5 in q16.16
  // ======================================================================
  function automatic vec_t predict_result(input vec_t v);
    samplerz_pkg::fx_t floor_fx;
    samplerz_pkg::fx_t r;
    samplerz_pkg::fx_t ccs;
    samplerz_pkg::fx_t d;
    samplerz_pkg::fx_t d_sqr;
    samplerz_pkg::fx_t t1;
    samplerz_pkg::fx_t t2;
    samplerz_pkg::fx_t x;
    samplerz_pkg::fx_t t;
    samplerz_pkg::fx_t sigma_min;
    longint            p;
    int                z0;
    int                z;
    int                s;
    int                k;
    floor_fx  = {v.mu[31:16], 16'h0000};          // fraction cleared
    r         = v.mu - floor_fx;
    sigma_min = v.ftype ? `SZ_SIGMA_MIN_1024 : `SZ_SIGMA_MIN_512;
    ccs       = samplerz_pkg::fx_t'((longint'(sigma_min) * longint'(v.isp)) >>> 16);
    z0 = 0;
    for (int i = 0; i < `SZ_RCDT_N; i++) begin
      if (samplerz_pkg::RCDT[i] > v.r72) z0++;
    end
    z     = v.r1 ? (1 + z0) : -z0;
    d     = samplerz_pkg::fx_t'(z * 65536) - r;
    d_sqr = samplerz_pkg::fx_t'((longint'(d) * longint'(d)) >>> 16);
    t1    = samplerz_pkg::fx_t'((longint'(d_sqr) * longint'(v.isq)) >>> 16);
    t2    = samplerz_pkg::fx_t'(z0 * z0 * `SZ_INV_SMAX_SQR_DIV_2);
    x     = t1 - t2;
    if (x < 0) x = 0;                              // clamp
    t = samplerz_pkg::fx_t'((longint'(x) * `SZ_INV_LN2) >>> 16);
    s = t >>> 16;                                  // integer part
    k = (t >>> 11) & 31;                           // top 5 fraction bits
    p = (longint'(ccs) * longint'(samplerz_pkg::EXP2_LUT[k])) >>> 16;
    p = (s >= 16) ? 0 : (p >>> s);
    v.acc = (longint'(v.r8) * 256) < p;
    v.w   = samplerz_pkg::zint_t'(z + (v.mu >>> 16));
    return v;
  endfunction

  function automatic bit center_differs(input vec_t a, input vec_t b);
    return (a.mu != b.mu) || (a.isp != b.isp) || (a.isq != b.isq) || (a.ftype != b.ftype);
  endfunction

  // ======================================================================
  // vector table
  // ======================================================================
  task automatic add_hand(input int idx, input samplerz_pkg::fx_t mu,
                          input samplerz_pkg::fx_t isp, input bit ft,
                          input samplerz_pkg::rand_t r72, input logic [7:0] r8,
                          input bit r1, input bit acc, input samplerz_pkg::zint_t w);
    vecs[idx] = '{mu, isp, ISQ, ft, r72, r8, r1, acc, w};
  endtask

  task automatic build_table();
    vec_t v;
    add_hand(0, 32'sh0000_0000, ISP_ONE, 1'b0, R72_TOP, 8'd0, 1'b0, 1'b1, 16'sd0);    // sure accept
    add_hand(1, 32'sh0000_0000, ISP_LOW, 1'b0, R72_TOP, 8'd255, 1'b0, 1'b0, 16'sd0);  // sure reject
    add_hand(2, 32'sh0003_4000, ISP_ONE, 1'b0, R72_TOP, 8'd0, 1'b1, 1'b1, 16'sd4);    // mu 3.25
    add_hand(3, 32'shFFFD_4000, ISP_ONE, 1'b0, R72_Z0_1, 8'd0, 1'b1, 1'b1, -16'sd1);  // mu -2.75
    add_hand(4, 32'shFFFB_0000, ISP_ONE, 1'b0, R72_TOP, 8'd0, 1'b1, 1'b1, -16'sd4);   // mu -5.0
    add_hand(5, 32'sh0000_0000, ISP_EDGE, 1'b0, R72_TOP, 8'd255, 1'b0, 1'b0, 16'sd0); // p 64998
    add_hand(6, 32'sh0000_0000, ISP_EDGE, 1'b1, R72_TOP, 8'd255, 1'b0, 1'b1, 16'sd0); // p 66037
    // random rows share one center, issued back to back
    for (int i = N_HAND; i < N_VECS; i++) begin
      v.mu    = 32'sh0001_999A;                    // 1.6
      v.isp   = ISP_ONE;
      v.isq   = ISQ;
      v.ftype = 1'b1;
      v.r72   = samplerz_pkg::rand_t'({$urandom, $urandom, $urandom})
                >> ($urandom % 40);                // spread z0
      v.r8    = 8'($urandom % 256);
      v.r1    = 1'($urandom % 2);
      vecs[i] = predict_result(v);
    end
  endtask

  // ======================================================================
  // drive side, every call starts 1 ns after a rising edge
  // ======================================================================
  task automatic wait_idle();
    @(posedge clk);
    #1;
    rand_val_i = 1'b0;
    while (expect_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic load_center(input vec_t v);
    wait_idle();                                   // no attempt in flight
    din_val_i         = 1'b1;
    mu_i              = v.mu;
    inv_sigma_prime_i = v.isp;
    isp_sqr_div_2_i   = v.isq;
    falcon_type_i     = v.ftype;
    @(posedge clk);
    #1;
    din_val_i = 1'b0;
    @(posedge clk);                                // center settles
    #1;
  endtask

  task automatic issue_attempt(input vec_t v, input bit track);
    pending_t e;
    rand_val_i = 1'b1;
    rand_72_i  = v.r72;
    rand_8_i   = v.r8;
    rand_1_i   = v.r1;
    if (track) begin
      e.due = cyc + `SZ_ATTEMPT_LAT;
      e.acc = v.acc;
      e.w   = v.w;
      expect_q.push_back(e);
    end
  endtask

  // ======================================================================
  // compare tasks and collector
  // ======================================================================
  task automatic check_sample(input samplerz_pkg::zint_t got, input samplerz_pkg::zint_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t w_o got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_decision(input bit got_acc, input bit exp_acc);
    checks++;
    if (got_acc !== exp_acc) begin
      value_errors++;
      $display("[FAIL] %0t dout_val_o got %0b expected %0b", $time, got_acc, exp_acc);
    end
  endtask

  // outputs read at the falling edge, away from register updates
  always @(negedge clk) begin : collect
    pending_t e;
    if (dout_val_o === 1'b1 && request_rand_o === 1'b1) begin
      other_errors++;
      $display("%0t: dout_val_o and request_rand_o are high in the same cycle", $time);
    end
    if (dout_val_o === 1'b1 || request_rand_o === 1'b1) begin
      if (expect_q.size() == 0) begin
        other_errors++;
        $display("%0t: result strobe with no attempt in flight", $time);
      end else begin
        e = expect_q.pop_front();
        if (e.due != cyc) begin
          other_errors++;
          $display("%0t: result came at cycle %0d, expected at cycle %0d", $time, cyc, e.due);
        end
        check_decision(dout_val_o === 1'b1, e.acc);
        if (e.acc && dout_val_o === 1'b1) check_sample(w_o, e.w);
      end
    end else if (expect_q.size() != 0 && expect_q[0].due <= cyc) begin
      other_errors++;
      $display("%0t: no result for the attempt due at cycle %0d", $time, expect_q[0].due);
      e = expect_q.pop_front();
    end
  end

  // ======================================================================
  // main sequence
  // ======================================================================
  initial begin : main
    rst_i             = 1'b1;
    din_val_i         = 1'b0;
    mu_i              = '0;
    inv_sigma_prime_i = '0;
    isp_sqr_div_2_i   = '0;
    falcon_type_i     = 1'b0;
    rand_val_i        = 1'b0;
    rand_72_i         = '0;
    rand_8_i          = '0;
    rand_1_i          = 1'b0;
    void'($urandom(54));
    build_table();
    repeat (3) @(posedge clk);
    #1;
    rst_i = 1'b0;

    for (int i = 0; i < N_VECS; i++) begin
      if (i == 0 || center_differs(vecs[i], vecs[i-1])) load_center(vecs[i]);
      @(posedge clk);
      #1;
      issue_attempt(vecs[i], 1'b1);
    end
    wait_idle();

    // reset cuts off three attempts in flight
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      #1;
      issue_attempt(vecs[N_HAND + i], 1'b0);
    end
    @(posedge clk);
    #1;
    rand_val_i = 1'b0;
    rst_i      = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_i = 1'b0;
    repeat (12) @(posedge clk);                    // any stray strobe is flagged
    load_center(vecs[0]);
    @(posedge clk);
    #1;
    issue_attempt(vecs[0], 1'b1);
    wait_idle();

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    #((N_VECS * 12 + 50) * CLK_PERIOD);
    $display("timeout after %0d clock periods, run did not complete", N_VECS * 12 + 50);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/samplerz_asserts.sv ====
// concurrent checks on the sampler result strobes
// bound into samplerz_top
`timescale 1ns/100ps
`default_nettype none

`include "samplerz_defines.svh"

module samplerz_asserts (
  input wire clk,
  input wire rst_i,
  input wire rand_val_i,
  input wire dout_val_i,      // dout_val_o of the top
  input wire request_rand_i   // request_rand_o of the top
);

  // a strobe only for an attempt issued 7 cycles back, never both at once
  a_exclusive: assert property (@(posedge clk) disable iff (rst_i)
    (dout_val_i || request_rand_i) |->
      (!(dout_val_i && request_rand_i) && $past(rand_val_i, `SZ_ATTEMPT_LAT)))
    else $error("result strobe with no attempt behind it, or both strobes high");

  // each attempt ends in exactly one strobe, fixed latency
  a_one_result: assert property (@(posedge clk) disable iff (rst_i)
    rand_val_i |-> ##`SZ_ATTEMPT_LAT (dout_val_i ^ request_rand_i))
    else $error("attempt did not end in exactly one result strobe");

  // strobes cleared by reset
  a_reset_quiet: assert property (@(posedge clk)
    rst_i |=> (!dout_val_i && !request_rand_i))
    else $error("result strobe high after reset was applied");

endmodule

bind samplerz_top samplerz_asserts asserts_i (
  .clk            (clk),
  .rst_i          (rst_i),
  .rand_val_i     (rand_val_i),
  .dout_val_i     (dout_val_o),
  .request_rand_i (request_rand_o)
);

`default_nettype wire

// ==== source/samplerz_top.sv ====
// gaussian integer sampler top level
// center prep plus four stage attempt pipeline, 7 cycles per attempt
`timescale 1ns/100ps
`default_nettype none

module samplerz_top (
  input  wire                 clk,
  input  wire                 rst_i,

  // center and per-leaf values
  input  wire                 din_val_i,
  input  samplerz_pkg::fx_t   mu_i,
  input  samplerz_pkg::fx_t   inv_sigma_prime_i,
  input  samplerz_pkg::fx_t   isp_sqr_div_2_i,
  input  wire                 falcon_type_i,    // 0 = 512, 1 = 1024

  // one strobe per attempt
  input  wire                 rand_val_i,
  input  samplerz_pkg::rand_t rand_72_i,
  input  wire  [7:0]          rand_8_i,
  input  wire                 rand_1_i,

  output logic                dout_val_o,
  output samplerz_pkg::zint_t w_o,
  output logic                request_rand_o
);

  // center values, held between din_val_i strobes
  samplerz_pkg::zint_t mu_floor;
  samplerz_pkg::fx_t   r;
  samplerz_pkg::fx_t   ccs;
  samplerz_pkg::fx_t   isp_sqr_div_2;

  // stage 1 -> 2
  logic                cand_val;
  samplerz_pkg::zint_t cand_z;
  samplerz_pkg::fx_t   cand_z0_sqr;
  logic [7:0]          cand_rand_8;

  // stage 2 -> 3
  logic                x_val;
  samplerz_pkg::fx_t   x;
  samplerz_pkg::zint_t x_z;
  logic [7:0]          x_rand_8;

  // stage 3 -> 4
  logic                decision_val;
  logic                accept;
  samplerz_pkg::zint_t decision_z;

  center_prep center_prep_i (
    .clk               (clk),
    .rst_i             (rst_i),
    .din_val_i         (din_val_i),
    .mu_i              (mu_i),
    .inv_sigma_prime_i (inv_sigma_prime_i),
    .isp_sqr_div_2_i   (isp_sqr_div_2_i),
    .falcon_type_i     (falcon_type_i),
    .mu_floor_o        (mu_floor),
    .r_o               (r),
    .ccs_o             (ccs),
    .isp_sqr_div_2_o   (isp_sqr_div_2)
  );

  base_candidate base_candidate_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .rand_val_i (rand_val_i),
    .rand_72_i  (rand_72_i),
    .rand_8_i   (rand_8_i),
    .rand_1_i   (rand_1_i),
    .cand_val_o (cand_val),
    .z_o        (cand_z),
    .z0_sqr_o   (cand_z0_sqr),
    .rand_8_o   (cand_rand_8)
  );

  exponent_calc exponent_calc_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .cand_val_i      (cand_val),
    .z_i             (cand_z),
    .z0_sqr_i        (cand_z0_sqr),
    .rand_8_i        (cand_rand_8),
    .r_i             (r),
    .isp_sqr_div_2_i (isp_sqr_div_2),
    .x_val_o         (x_val),
    .x_o             (x),
    .z_o             (x_z),
    .rand_8_o        (x_rand_8)
  );

  bernoulli_accept bernoulli_accept_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .x_val_i        (x_val),
    .x_i            (x),
    .z_i            (x_z),
    .rand_8_i       (x_rand_8),
    .ccs_i          (ccs),
    .decision_val_o (decision_val),
    .accept_o       (accept),
    .z_o            (decision_z)
  );

  sample_select sample_select_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .decision_val_i (decision_val),
    .accept_i       (accept),
    .z_i            (decision_z),
    .mu_floor_i     (mu_floor),
    .dout_val_o     (dout_val_o),
    .w_o            (w_o),
    .request_rand_o (request_rand_o)
  );

endmodule

`default_nettype wire

// ==== source/sample_select.sv ====
// result stage, w = z + floor(mu) on accept
// reject pulses request_rand_o for fresh randomness
`timescale 1ns/100ps
`default_nettype none

module sample_select (
  input  wire                 clk,
  input  wire                 rst_i,
  input  wire                 decision_val_i,
  input  wire                 accept_i,
  input  samplerz_pkg::zint_t z_i,
  input  samplerz_pkg::zint_t mu_floor_i,
  output logic                dout_val_o,
  output samplerz_pkg::zint_t w_o,
  output logic                request_rand_o
);

  logic                dout_val_q;
  logic                request_q;
  samplerz_pkg::zint_t w_q;

  // strobes, never both high
  always_ff @(posedge clk) begin
    if (rst_i) begin
      dout_val_q <= 1'b0;
      request_q  <= 1'b0;
    end else begin
      dout_val_q <= decision_val_i & accept_i;
      request_q  <= decision_val_i & ~accept_i;
    end
  end

  always_ff @(posedge clk) begin
    if (decision_val_i && accept_i) w_q <= z_i + mu_floor_i;   // back to the center
  end

  assign dout_val_o     = dout_val_q;
  assign w_o            = w_q;
  assign request_rand_o = request_q;

endmodule

`default_nettype wire

// ==== source/bernoulli_accept.sv ====
// bernoulli trial with probability ccs * exp(-x)
// exp(-x) = 2^(-t), t = x / ln2, table on the fraction and shift on the integer
`timescale 1ns/100ps
`default_nettype none

`include "samplerz_defines.svh"

module bernoulli_accept (
  input  wire                 clk,
  input  wire                 rst_i,
  input  wire                 x_val_i,
  input  samplerz_pkg::fx_t   x_i,
  input  samplerz_pkg::zint_t z_i,
  input  wire  [7:0]          rand_8_i,
  input  samplerz_pkg::fx_t   ccs_i,
  output logic                decision_val_o,
  output logic                accept_o,
  output samplerz_pkg::zint_t z_o
);

  logic signed [63:0]          t_full;
  samplerz_pkg::fx_t           t;
  logic                        s1_val_q;
  logic [`SZ_INT_W-1:0]        s_q;     // integer part of t, shift amount
  logic [`SZ_EXP_LUT_BITS-1:0] k_q;     // table index
  samplerz_pkg::zint_t         z_q1;
  logic [7:0]                  rand_8_q1;

  samplerz_pkg::prob_t         lut_val;
  logic [47:0]                 ccs_prod;
  logic [31:0]                 p_base;
  logic [31:0]                 p;
  logic                        accept_d;

  logic                        decision_val_q;
  logic                        accept_q;
  samplerz_pkg::zint_t         z_q2;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      s1_val_q       <= 1'b0;
      decision_val_q <= 1'b0;
    end else begin
      s1_val_q       <= x_val_i;
      decision_val_q <= s1_val_q;
    end
  end

  // ====================================================================
  // stage 1, t = x / ln2, x is never negative here
  // ====================================================================
  assign t_full = x_i * samplerz_pkg::fx_t'(`SZ_INV_LN2);
  assign t      = t_full[`SZ_FX_W+`SZ_FRAC_W-1:`SZ_FRAC_W];

  always_ff @(posedge clk) begin
    s_q       <= t[`SZ_FX_W-1:`SZ_FRAC_W];
    k_q       <= t[`SZ_FRAC_W-1:`SZ_FRAC_W-`SZ_EXP_LUT_BITS];   // top fraction bits
    z_q1      <= z_i;
    rand_8_q1 <= rand_8_i;
  end

  // ====================================================================
  // stage 2, p = (ccs * 2^(-k/32)) >> s, then compare
  // ====================================================================
  assign lut_val  = samplerz_pkg::EXP2_LUT[k_q];
  assign ccs_prod = $unsigned(ccs_i) * lut_val;   // ccs is positive
  assign p_base   = ccs_prod[47:`SZ_FRAC_W];
  assign p        = (|s_q[`SZ_INT_W-1:4]) ? '0 : (p_base >> s_q[3:0]);  // s >= 16 gives 0
  assign accept_d = {16'b0, rand_8_q1, 8'b0} < p;

  always_ff @(posedge clk) begin
    accept_q <= accept_d;
    z_q2     <= z_q1;
  end

  assign decision_val_o = decision_val_q;
  assign accept_o       = accept_q;
  assign z_o            = z_q2;

endmodule

`default_nettype wire

// ==== source/exponent_calc.sv ====
// rejection exponent for one attempt
// x = ((z - r)^2 * isp_sqr_div_2) - z0^2 / (2 sigma_max^2), clamped at 0
`timescale 1ns/100ps
`default_nettype none

`include "samplerz_defines.svh"

module exponent_calc (
  input  wire                 clk,
  input  wire                 rst_i,
  input  wire                 cand_val_i,
  input  samplerz_pkg::zint_t z_i,
  input  samplerz_pkg::fx_t   z0_sqr_i,
  input  wire  [7:0]          rand_8_i,
  input  samplerz_pkg::fx_t   r_i,
  input  samplerz_pkg::fx_t   isp_sqr_div_2_i,
  output logic                x_val_o,
  output samplerz_pkg::fx_t   x_o,
  output samplerz_pkg::zint_t z_o,
  output logic [7:0]          rand_8_o
);

  logic [2:0]          val_q;          // one bit per stage
  samplerz_pkg::zint_t z_d [3];
  logic [7:0]          rand_8_d [3];

  samplerz_pkg::fx_t   d_q;            // z - r
  samplerz_pkg::fx_t   z0_sqr_q;
  logic signed [63:0]  d_sqr_full;
  logic signed [63:0]  t2_full;
  samplerz_pkg::fx_t   d_sqr_q;
  samplerz_pkg::fx_t   t2_q;           // z0^2 term
  logic signed [63:0]  t1_full;
  samplerz_pkg::fx_t   t1;
  samplerz_pkg::fx_t   x_diff;
  samplerz_pkg::fx_t   x_q;

  always_ff @(posedge clk) begin
    if (rst_i) val_q <= '0;
    else       val_q <= {val_q[1:0], cand_val_i};
  end

  // z and rand_8 ride along
  always_ff @(posedge clk) begin
    z_d[0]      <= z_i;
    z_d[1]      <= z_d[0];
    z_d[2]      <= z_d[1];
    rand_8_d[0] <= rand_8_i;
    rand_8_d[1] <= rand_8_d[0];
    rand_8_d[2] <= rand_8_d[1];
  end

  // ====================================================================
  // stage 1, z - r
  // ====================================================================
  always_ff @(posedge clk) begin
    d_q      <= samplerz_pkg::fx_t'({z_i, {`SZ_FRAC_W{1'b0}}}) - r_i;
    z0_sqr_q <= z0_sqr_i;
  end

  // ====================================================================
  // stage 2, squares
  // ====================================================================
  assign d_sqr_full = d_q * d_q;
  assign t2_full    = z0_sqr_q * samplerz_pkg::fx_t'(`SZ_INV_SMAX_SQR_DIV_2);

  always_ff @(posedge clk) begin
    d_sqr_q <= d_sqr_full[`SZ_FX_W+`SZ_FRAC_W-1:`SZ_FRAC_W];  // >>> 16
    t2_q    <= t2_full[`SZ_FX_W+`SZ_FRAC_W-1:`SZ_FRAC_W];
  end

  // ====================================================================
  // stage 3, scale, subtract, clamp
  // ====================================================================
  assign t1_full = d_sqr_q * isp_sqr_div_2_i;
  assign t1      = t1_full[`SZ_FX_W+`SZ_FRAC_W-1:`SZ_FRAC_W];
  assign x_diff  = t1 - t2_q;

  always_ff @(posedge clk) begin
    x_q <= x_diff[`SZ_FX_W-1] ? '0 : x_diff;   // negative x -> 0
  end

  assign x_val_o  = val_q[2];
  assign x_o      = x_q;
  assign z_o      = z_d[2];
  assign rand_8_o = rand_8_d[2];

endmodule

`default_nettype wire

// ==== source/base_candidate.sv ====
// base sampler and sign step
// parallel reverse cdf compare, z = 1 + z0 or -z0, z0 squared
`timescale 1ns/100ps
`default_nettype none

`include "samplerz_defines.svh"

module base_candidate (
  input  wire                 clk,
  input  wire                 rst_i,
  input  wire                 rand_val_i,
  input  samplerz_pkg::rand_t rand_72_i,
  input  wire  [7:0]          rand_8_i,
  input  wire                 rand_1_i,
  output logic                cand_val_o,
  output samplerz_pkg::zint_t z_o,
  output samplerz_pkg::fx_t   z0_sqr_o,
  output logic [7:0]          rand_8_o
);

  logic [4:0]          z0_cnt;     // 0..18
  logic [9:0]          z0_sq;      // at most 324
  samplerz_pkg::zint_t z0_ext;
  samplerz_pkg::zint_t z_next;

  logic                cand_val_q;
  samplerz_pkg::zint_t z_q;
  samplerz_pkg::fx_t   z0_sqr_q;
  logic [7:0]          rand_8_q;

  // ====================================================================
  // z0 = number of thresholds above the random word
  // ====================================================================
  always_comb begin
    z0_cnt = '0;
    for (int i = 0; i < `SZ_RCDT_N; i++) begin
      if (samplerz_pkg::RCDT[i] > rand_72_i) begin
        z0_cnt = z0_cnt + 5'd1;
      end
    end
  end

  assign z0_ext = samplerz_pkg::zint_t'(z0_cnt);   // zero extend
  assign z0_sq  = z0_cnt * z0_cnt;

  // sign bit picks the side of the half gaussian
  assign z_next = rand_1_i ? (z0_ext + 16'sd1) : -z0_ext;

  always_ff @(posedge clk) begin
    if (rst_i) cand_val_q <= 1'b0;
    else       cand_val_q <= rand_val_i;
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (rand_val_i) begin
      z_q      <= z_next;
      z0_sqr_q <= samplerz_pkg::fx_t'({z0_sq, {`SZ_FRAC_W{1'b0}}});  // integer to q16.16
      rand_8_q <= rand_8_i;         // consumed later by the bernoulli trial
    end
  end

  assign cand_val_o = cand_val_q;
  assign z_o        = z_q;
  assign z0_sqr_o   = z0_sqr_q;
  assign rand_8_o   = rand_8_q;

endmodule

`default_nettype wire

// ==== source/center_prep.sv ====
// center preparation for the sampler
// latches mu and sigma values, forms floor(mu), r and ccs in two cycles
`timescale 1ns/100ps
`default_nettype none

`include "samplerz_defines.svh"

module center_prep (
  input  wire                 clk,
  input  wire                 rst_i,
  input  wire                 din_val_i,
  input  samplerz_pkg::fx_t   mu_i,
  input  samplerz_pkg::fx_t   inv_sigma_prime_i,
  input  samplerz_pkg::fx_t   isp_sqr_div_2_i,
  input  wire                 falcon_type_i,
  output samplerz_pkg::zint_t mu_floor_o,
  output samplerz_pkg::fx_t   r_o,
  output samplerz_pkg::fx_t   ccs_o,
  output samplerz_pkg::fx_t   isp_sqr_div_2_o
);

  logic                prep_val_q;     // second cycle of the center load
  samplerz_pkg::fx_t   mu_q;
  samplerz_pkg::fx_t   isp_q;          // inv_sigma_prime
  samplerz_pkg::fx_t   isp_sqr_q;
  logic                falcon_type_q;
  samplerz_pkg::fx_t   sigma_min;
  logic signed [63:0]  ccs_prod;       // q32.32 product
  samplerz_pkg::zint_t floor_q;
  samplerz_pkg::fx_t   r_q;
  samplerz_pkg::fx_t   ccs_q;

  // ====================================================================
  // cycle 1, latch inputs
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst_i) prep_val_q <= 1'b0;
    else       prep_val_q <= din_val_i;
  end

  always_ff @(posedge clk) begin
    if (din_val_i) begin
      mu_q          <= mu_i;
      isp_q         <= inv_sigma_prime_i;
      isp_sqr_q     <= isp_sqr_div_2_i;
      falcon_type_q <= falcon_type_i;
    end
  end

  // ====================================================================
  // cycle 2, floor / fraction split and ccs
  // ====================================================================
  assign sigma_min = falcon_type_q ? `SZ_SIGMA_MIN_1024 : `SZ_SIGMA_MIN_512;
  assign ccs_prod  = sigma_min * isp_q;

  always_ff @(posedge clk) begin
    if (prep_val_q) begin
      floor_q <= mu_q[`SZ_FX_W-1:`SZ_FRAC_W];   // integer bits are already floor
      r_q     <= {{(`SZ_FX_W-`SZ_FRAC_W){1'b0}}, mu_q[`SZ_FRAC_W-1:0]};
      ccs_q   <= ccs_prod[`SZ_FX_W+`SZ_FRAC_W-1:`SZ_FRAC_W];  // back to q16.16
    end
  end

  assign mu_floor_o      = floor_q;
  assign r_o             = r_q;
  assign ccs_o           = ccs_q;
  assign isp_sqr_div_2_o = isp_sqr_q;

endmodule

`default_nettype wire

// ==== source/samplerz_pkg.sv ====
// shared types for the sampler datapath
// reverse cdf thresholds and 2^(-k/32) table
`default_nettype none

`include "samplerz_defines.svh"

package samplerz_pkg;

  typedef logic signed [`SZ_FX_W-1:0]  fx_t;    // signed q16.16
  typedef logic signed [`SZ_INT_W-1:0] zint_t;  // integer sample
  typedef logic [`SZ_RAND_W-1:0]       rand_t;
  typedef logic [15:0]                 prob_t;  // unsigned q0.16

  // ====================================================================
  // reverse cdf of the half gaussian, three 24-bit limbs per entry
  // ====================================================================
  localparam rand_t RCDT [`SZ_RCDT_N] = '{
    {24'd10745844, 24'd3068844,  24'd3741698},
    {24'd5559083,  24'd1580863,  24'd8248194},
    {24'd2260429,  24'd13669192, 24'd2736639},
    {24'd708981,   24'd4421575,  24'd10046180},
    {24'd169348,   24'd7122675,  24'd4136815},
    {24'd30538,    24'd13063405, 24'd7650655},
    {24'd4132,     24'd14505003, 24'd7826148},
    {24'd417,      24'd16768101, 24'd11363290},
    {24'd31,       24'd8444042,  24'd8086568},
    {24'd1,        24'd12844466, 24'd265321},
    {24'd0,        24'd1232676,  24'd13644283},
    {24'd0,        24'd38047,    24'd9111839},
    {24'd0,        24'd870,      24'd6138264},
    {24'd0,        24'd14,       24'd12545723},
    {24'd0,        24'd0,        24'd3104126},
    {24'd0,        24'd0,        24'd28824},
    {24'd0,        24'd0,        24'd198},
    {24'd0,        24'd0,        24'd1}
  };

  // ====================================================================
  // 2^(-k/32) in q0.16, entry 0 saturates at all ones
  // ====================================================================
  localparam prob_t EXP2_LUT [1 << `SZ_EXP_LUT_BITS] = '{
    16'd65535, 16'd64132, 16'd62757, 16'd61413,
    16'd60097, 16'd58809, 16'd57549, 16'd56315,
    16'd55109, 16'd53928, 16'd52773, 16'd51642,
    16'd50535, 16'd49452, 16'd48393, 16'd47356,
    16'd46341, 16'd45348, 16'd44376, 16'd43425,
    16'd42495, 16'd41584, 16'd40693, 16'd39821,
    16'd38968, 16'd38133, 16'd37316, 16'd36516,
    16'd35734, 16'd34968, 16'd34219, 16'd33486
  };

endpackage

`default_nettype wire

// ==== source/samplerz_defines.svh ====
// widths and q16.16 constants for the gaussian sampler
// sigma and ln2 constants rounded to nearest lsb
`ifndef SAMPLERZ_DEFINES_SVH
`define SAMPLERZ_DEFINES_SVH

// ======================================================================
// widths
// ======================================================================
`define SZ_FX_W          32  // every fixed-point word
`define SZ_FRAC_W        16  // fraction bits of q16.16
`define SZ_INT_W         16  // integer sample width
`define SZ_RAND_W        72  // base sampler random word
`define SZ_RCDT_N        18  // reverse cdf entries
`define SZ_EXP_LUT_BITS  5   // fraction bits into exp2 table

// ======================================================================
// q16.16 constants
// ======================================================================
// sigma_min per parameter set
`define SZ_SIGMA_MIN_512        32'sd83744   // 1.277833697
`define SZ_SIGMA_MIN_1024       32'sd85084   // 1.298280334

// sigma_max = 1.8205
`define SZ_INV_SMAX_SQR_DIV_2   32'sd9887    // 0.150865049

`define SZ_INV_LN2              32'sd94548   // 1.442695041

// rand_val_i to dout_val_o / request_rand_o
`define SZ_ATTEMPT_LAT  7

`endif
